// File: hw/mlp_pkg.sv
// ========================================
// sizes, layer tables, thresholds and
// struct types of the mlp engine
// ========================================

package mlp_pkg;

    localparam int DATA_WIDTH      = 64;
    localparam int ADDR_WIDTH      = 14;
    localparam int NUM_ARRAYS      = 3;
    localparam int ARRAY_DIM       = 16;
    localparam int TIME_STEPS      = 4;
    localparam int LANE_WIDTH      = 20;
    localparam int SUM_WIDTH       = 22;
    localparam int SLICE_BEATS     = 32;
    localparam int PSUM_PER_TILE   = 256;
    localparam int SPIKES_PER_WORD = 8;
    localparam int CREDIT_INIT     = 4;
    localparam int NUM_LAYERS      = 3;

    localparam int CREDIT_WIDTH    = $clog2(CREDIT_INIT + 1);
    localparam int WORDS_PER_TILE  = PSUM_PER_TILE / SPIKES_PER_WORD;
    // membrane headroom over four accumulated lanes
    localparam int MEM_WIDTH       = SUM_WIDTH + 2;

    // index 0 is the projection layer
    localparam logic [NUM_LAYERS-1:0][7:0] LAYER_ROWS = {8'd6, 8'd3, 8'd3};
    localparam logic [NUM_LAYERS-1:0][7:0] LAYER_COLS = {8'd2, 8'd4, 8'd2};
    localparam logic [NUM_LAYERS-1:0][MEM_WIDTH-1:0] LAYER_THRESH = {
        MEM_WIDTH'(128), MEM_WIDTH'(256), MEM_WIDTH'(128)
    };
    localparam logic [NUM_LAYERS-1:0][ADDR_WIDTH-1:0] RD_BASE = {
        ADDR_WIDTH'(2048), ADDR_WIDTH'(1024), ADDR_WIDTH'(0)
    };
    localparam logic [NUM_LAYERS-1:0][ADDR_WIDTH-1:0] WR_BASE = {
        ADDR_WIDTH'(3072), ADDR_WIDTH'(2048), ADDR_WIDTH'(1024)
    };

    typedef logic [1:0] layer_t;

    typedef struct packed {
        logic                  valid;
        logic                  last;
        logic [DATA_WIDTH-1:0] data;
    } slice_beat_t;

    typedef struct packed {
        logic                 valid;
        logic [ARRAY_DIM-1:0] grant;
    } psum_req_t;

    // lane 0 holds time step 0
    typedef logic signed [TIME_STEPS-1:0][LANE_WIDTH-1:0] psum_lanes_t;

    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } mem_wr_t;

endpackage

// File: hw/mlp_sequencer.sv
// ========================================
// layer and tile control FSM with
// partial-sum fetch requests
// ========================================
`timescale 1ns/1ps

module mlp_sequencer (
    input  logic                           s_clk,
    input  logic                           s_rst,
    input  logic                           i_start,
    input  logic                           i_load_done,
    input  logic [mlp_pkg::NUM_ARRAYS-1:0] i_calc_done,
    output logic                           o_load_start,
    output mlp_pkg::layer_t                o_layer,
    output mlp_pkg::psum_req_t             o_psum_req,
    output logic                           o_busy,
    output logic                           o_done
);
    import mlp_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_WAIT_CALC,
        ST_FETCH
    } state_t;

    state_t                           r_state;
    logic [7:0]                       r_tile;
    logic [NUM_ARRAYS-1:0]            r_calc_seen;
    logic [$clog2(PSUM_PER_TILE)-1:0] r_req_cnt;
    logic                             w_last_tile;
    logic                             w_last_layer;

    assign w_last_tile  = (r_tile == LAYER_COLS[o_layer] - 8'd1);
    assign w_last_layer = (o_layer == layer_t'(NUM_LAYERS - 1));

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_state      <= ST_IDLE;
            r_tile       <= '0;
            r_calc_seen  <= '0;
            r_req_cnt    <= '0;
            o_layer      <= '0;
            o_psum_req   <= '0;
            o_load_start <= 1'b0;
            o_busy       <= 1'b0;
            o_done       <= 1'b0;
        end else begin
            o_load_start <= 1'b0;
            o_done       <= 1'b0;
            // finish pulses can come in any order, even before load_done
            if (r_state == ST_LOAD || r_state == ST_WAIT_CALC)
                r_calc_seen <= r_calc_seen | i_calc_done;
            case (r_state)
                ST_IDLE: begin
                    if (i_start) begin
                        r_state      <= ST_LOAD;
                        r_tile       <= '0;
                        o_layer      <= '0;
                        o_load_start <= 1'b1;
                        o_busy       <= 1'b1;
                    end
                end
                ST_LOAD: begin
                    if (i_load_done)
                        r_state <= ST_WAIT_CALC;
                end
                ST_WAIT_CALC: begin
                    if (&r_calc_seen) begin
                        r_state          <= ST_FETCH;
                        r_req_cnt        <= '0;
                        o_psum_req.valid <= 1'b1;
                        o_psum_req.grant <= ARRAY_DIM'(1);
                    end
                end
                ST_FETCH: begin
                    r_req_cnt <= r_req_cnt + 1'b1;
                    // next row every ARRAY_DIM requests
                    if (&r_req_cnt[$clog2(ARRAY_DIM)-1:0])
                        o_psum_req.grant <= {o_psum_req.grant[ARRAY_DIM-2:0],
                                             o_psum_req.grant[ARRAY_DIM-1]};
                    if (&r_req_cnt) begin
                        o_psum_req  <= '0;
                        r_calc_seen <= '0;
                        if (!w_last_tile) begin
                            r_tile       <= r_tile + 8'd1;
                            r_state      <= ST_LOAD;
                            o_load_start <= 1'b1;
                        end else if (!w_last_layer) begin
                            r_tile       <= '0;
                            o_layer      <= o_layer + 1'b1;
                            r_state      <= ST_LOAD;
                            o_load_start <= 1'b1;
                        end else begin
                            r_tile  <= '0;
                            r_state <= ST_IDLE;
                            o_busy  <= 1'b0;
                            o_done  <= 1'b1;
                        end
                    end
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: hw/slice_streamer.sv
// ========================================
// slice reads with per-array credits and
// round-robin delivery
// ========================================
`timescale 1ns/1ps

module slice_streamer (
    input  logic                                           s_clk,
    input  logic                                           s_rst,
    input  logic                                           i_load_start,
    input  mlp_pkg::layer_t                                i_layer,
    input  logic [mlp_pkg::DATA_WIDTH-1:0]                 i_rd_data,
    input  logic [mlp_pkg::NUM_ARRAYS-1:0]                 i_credit,
    output logic [mlp_pkg::ADDR_WIDTH-1:0]                 o_rd_addr,
    output mlp_pkg::slice_beat_t [mlp_pkg::NUM_ARRAYS-1:0] o_slice,
    output logic                                           o_load_done
);
    import mlp_pkg::*;

    logic                                     r_active;
    layer_t                                   r_layer;
    logic [$clog2(SLICE_BEATS)-1:0]           r_beat;
    logic [7:0]                               r_slice;
    logic [1:0]                               r_chan;
    logic [NUM_ARRAYS-1:0][CREDIT_WIDTH-1:0]  r_credit;
    logic                                     r_beat_vld;
    logic                                     r_beat_last;
    logic [1:0]                               r_beat_chan;
    logic                                     w_issue;

    // a read only goes out with a credit reserved on its channel
    assign w_issue     = r_active && (r_credit[r_chan] != '0);
    assign o_load_done = w_issue && (&r_beat) && (r_slice == LAYER_ROWS[r_layer] - 8'd1);
    // slice * SLICE_BEATS + beat
    assign o_rd_addr   = RD_BASE[r_layer] + ADDR_WIDTH'({r_slice, r_beat});

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_active    <= 1'b0;
            r_layer     <= '0;
            r_beat      <= '0;
            r_slice     <= '0;
            r_chan      <= '0;
            r_beat_vld  <= 1'b0;
            r_beat_last <= 1'b0;
            r_beat_chan <= '0;
        end else begin
            // memory data returns one cycle after the address
            r_beat_vld  <= w_issue;
            r_beat_last <= w_issue && (&r_beat);
            r_beat_chan <= r_chan;
            if (i_load_start) begin
                r_active <= 1'b1;
                r_layer  <= i_layer;
                r_beat   <= '0;
                r_slice  <= '0;
                r_chan   <= '0;
            end else if (w_issue) begin
                r_beat <= r_beat + 1'b1;
                if (&r_beat) begin
                    r_slice <= r_slice + 8'd1;
                    r_chan  <= (r_chan == 2'(NUM_ARRAYS - 1)) ? '0 : r_chan + 1'b1;
                    if (o_load_done)
                        r_active <= 1'b0;
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_ARRAYS; i++) begin : g_chan
        always_ff @(posedge s_clk or posedge s_rst) begin
            if (s_rst)
                r_credit[i] <= CREDIT_WIDTH'(CREDIT_INIT);
            else
                r_credit[i] <= r_credit[i] + CREDIT_WIDTH'(i_credit[i])
                             - CREDIT_WIDTH'(w_issue && r_chan == 2'(i));
        end

        assign o_slice[i].valid = r_beat_vld && (r_beat_chan == 2'(i));
        assign o_slice[i].last  = r_beat_last && (r_beat_chan == 2'(i));
        assign o_slice[i].data  = i_rd_data;
    end

endmodule

// File: hw/psum_combiner.sv
// ========================================
// lane-wise sum of the arrays' psums
// ========================================
`timescale 1ns/1ps

module psum_combiner (
    input  logic                                                       s_clk,
    input  logic                                                       s_rst,
    input  logic                                                       i_req_valid,
    input  mlp_pkg::layer_t                                            i_layer,
    input  mlp_pkg::psum_lanes_t [mlp_pkg::NUM_ARRAYS-1:0]             i_psum_data,
    output logic                                                       o_sum_valid,
    output mlp_pkg::layer_t                                            o_sum_layer,
    output logic [mlp_pkg::TIME_STEPS-1:0][mlp_pkg::SUM_WIDTH-1:0]     o_sum_lanes
);
    import mlp_pkg::*;

    logic                        r_req_valid;
    layer_t                      r_req_layer;
    logic signed [SUM_WIDTH-1:0] w_sum [TIME_STEPS];

    // lanes are sign-extended to SUM_WIDTH before the add
    always_comb begin
        for (int t = 0; t < TIME_STEPS; t++) begin
            w_sum[t] = '0;
            for (int a = 0; a < NUM_ARRAYS; a++)
                w_sum[t] = w_sum[t] + $signed(i_psum_data[a][t]);
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_req_valid <= 1'b0;
            r_req_layer <= '0;
            o_sum_valid <= 1'b0;
            o_sum_layer <= '0;
        end else begin
            // arrays answer one cycle after the request
            r_req_valid <= i_req_valid;
            r_req_layer <= i_layer;
            o_sum_valid <= r_req_valid;
            o_sum_layer <= r_req_layer;
        end
    end

    always_ff @(posedge s_clk) begin
        for (int t = 0; t < TIME_STEPS; t++)
            o_sum_lanes[t] <= w_sum[t];
    end

endmodule

// File: hw/lif_neuron.sv
// ========================================
// leaky integrate-and-fire over steps
// ========================================
`timescale 1ns/1ps

module lif_neuron (
    input  logic                                                   s_clk,
    input  logic                                                   s_rst,
    input  logic                                                   i_sum_valid,
    input  mlp_pkg::layer_t                                        i_sum_layer,
    input  logic [mlp_pkg::TIME_STEPS-1:0][mlp_pkg::SUM_WIDTH-1:0] i_sum_lanes,
    output logic                                                   o_spike_valid,
    output mlp_pkg::layer_t                                        o_spike_layer,
    output logic [mlp_pkg::TIME_STEPS-1:0]                         o_spikes
);
    import mlp_pkg::*;

    logic signed [MEM_WIDTH-1:0] w_mem;
    logic signed [MEM_WIDTH-1:0] w_thresh;
    logic [TIME_STEPS-1:0]       w_fire;

    assign w_thresh = LAYER_THRESH[i_sum_layer];

    // each sum feeds one neuron over steps 0 to 3
    always_comb begin
        w_mem = '0;
        for (int t = 0; t < TIME_STEPS; t++) begin
            w_mem     = w_mem + $signed(i_sum_lanes[t]);
            w_fire[t] = (w_mem >= w_thresh);
            // reset to zero on firing
            if (w_fire[t])
                w_mem = '0;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            o_spike_valid <= 1'b0;
        else
            o_spike_valid <= i_sum_valid;
    end

    always_ff @(posedge s_clk) begin
        o_spike_layer <= i_sum_layer;
        o_spikes      <= w_fire;
    end

endmodule

// File: hw/spike_packer.sv
// ========================================
// spike packing and write-back addressing
// ========================================
`timescale 1ns/1ps

module spike_packer (
    input  logic                           s_clk,
    input  logic                           s_rst,
    input  logic                           i_spike_valid,
    input  mlp_pkg::layer_t                i_spike_layer,
    input  logic [mlp_pkg::TIME_STEPS-1:0] i_spikes,
    output mlp_pkg::mem_wr_t               o_wr
);
    import mlp_pkg::*;

    logic [TIME_STEPS*2-1:0]              w_spk_ext;
    logic [ADDR_WIDTH-1:0]                w_widx_last;
    logic                                 w_word_full;
    logic [DATA_WIDTH-1:0]                r_word;
    logic [$clog2(SPIKES_PER_WORD)-1:0]   r_nidx;
    logic [ADDR_WIDTH-1:0]                r_widx;
    logic [ADDR_WIDTH-1:0]                r_wr_addr;
    logic                                 r_wr_en;

    // 2 bits per step with step 0 lowest
    always_comb begin
        for (int t = 0; t < TIME_STEPS; t++)
            w_spk_ext[2*t +: 2] = {1'b0, i_spikes[t]};
    end

    assign w_word_full = i_spike_valid && (&r_nidx);
    assign w_widx_last = ADDR_WIDTH'(LAYER_COLS[i_spike_layer] * WORDS_PER_TILE - 1);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_nidx  <= '0;
            r_widx  <= '0;
            r_wr_en <= 1'b0;
        end else begin
            r_wr_en <= w_word_full;
            if (i_spike_valid)
                r_nidx <= r_nidx + 1'b1;
            if (w_word_full)
                r_widx <= (r_widx == w_widx_last) ? '0 : r_widx + 1'b1;
        end
    end

    // shifted in from the top so neuron 0 ends up in bits 7:0
    always_ff @(posedge s_clk) begin
        if (i_spike_valid)
            r_word <= {w_spk_ext, r_word[DATA_WIDTH-1:TIME_STEPS*2]};
        if (w_word_full)
            r_wr_addr <= WR_BASE[i_spike_layer] + r_widx;
    end

    assign o_wr.en   = r_wr_en;
    assign o_wr.addr = r_wr_addr;
    assign o_wr.data = r_word;

endmodule

// File: hw/mlp_engine.sv
// ========================================
// top level wiring sequencer, streamer
// and datapath
// ========================================
`timescale 1ns/1ps

module mlp_engine (
    input  logic                                           s_clk,
    input  logic                                           s_rst,
    input  logic                                           i_start,
    input  logic [mlp_pkg::DATA_WIDTH-1:0]                 i_rd_data,
    input  logic [mlp_pkg::NUM_ARRAYS-1:0]                 i_credit,
    input  logic [mlp_pkg::NUM_ARRAYS-1:0]                 i_calc_done,
    input  mlp_pkg::psum_lanes_t [mlp_pkg::NUM_ARRAYS-1:0] i_psum_data,
    output logic                                           o_busy,
    output logic                                           o_done,
    output logic [mlp_pkg::ADDR_WIDTH-1:0]                 o_rd_addr,
    output mlp_pkg::slice_beat_t [mlp_pkg::NUM_ARRAYS-1:0] o_slice,
    output mlp_pkg::psum_req_t                             o_psum_req,
    output mlp_pkg::mem_wr_t                               o_wr
);
    import mlp_pkg::*;

    logic                                  w_load_start;
    logic                                  w_load_done;
    layer_t                                w_layer;
    logic                                  w_sum_valid;
    layer_t                                w_sum_layer;
    logic [TIME_STEPS-1:0][SUM_WIDTH-1:0]  w_sum_lanes;
    logic                                  w_spike_valid;
    layer_t                                w_spike_layer;
    logic [TIME_STEPS-1:0]                 w_spikes;

    mlp_sequencer u_mlp_sequencer (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_start      (i_start),
        .i_load_done  (w_load_done),
        .i_calc_done  (i_calc_done),
        .o_load_start (w_load_start),
        .o_layer      (w_layer),
        .o_psum_req   (o_psum_req),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    slice_streamer u_slice_streamer (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_load_start (w_load_start),
        .i_layer      (w_layer),
        .i_rd_data    (i_rd_data),
        .i_credit     (i_credit),
        .o_rd_addr    (o_rd_addr),
        .o_slice      (o_slice),
        .o_load_done  (w_load_done)
    );

    // layer travels with the psums down to the write-back
    psum_combiner u_psum_combiner (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_req_valid  (o_psum_req.valid),
        .i_layer      (w_layer),
        .i_psum_data  (i_psum_data),
        .o_sum_valid  (w_sum_valid),
        .o_sum_layer  (w_sum_layer),
        .o_sum_lanes  (w_sum_lanes)
    );

    lif_neuron u_lif_neuron (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_sum_valid   (w_sum_valid),
        .i_sum_layer   (w_sum_layer),
        .i_sum_lanes   (w_sum_lanes),
        .o_spike_valid (w_spike_valid),
        .o_spike_layer (w_spike_layer),
        .o_spikes      (w_spikes)
    );

    spike_packer u_spike_packer (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_spike_valid (w_spike_valid),
        .i_spike_layer (w_spike_layer),
        .i_spikes      (w_spikes),
        .o_wr          (o_wr)
    );

endmodule

// File: test/tb_mlp_engine.sv
// ========================================
// directed tests with memory and array models
// ========================================
`timescale 1ns/1ps

module tb_mlp_engine;
    import mlp_pkg::*;

    localparam int TOTAL_BEATS = 960;
    localparam int TOTAL_REQS  = 2048;
    localparam int TOTAL_TILES = 8;
    localparam int CYCLE_LIMIT = 2 * (TOTAL_BEATS * 10 + TOTAL_REQS + TOTAL_TILES * 64) + 1000;

    // per-layer rows, tiles, thresholds and memory regions
    int rows_tab[3]   = '{3, 3, 6};
    int cols_tab[3]   = '{2, 4, 2};
    int thresh_tab[3] = '{128, 256, 128};
    int rd_base[3]    = '{0, 1024, 2048};
    int wr_base[3]    = '{1024, 2048, 3072};

    logic s_clk;
    logic s_rst;
    logic i_start;
    logic [DATA_WIDTH-1:0] i_rd_data;
    logic [NUM_ARRAYS-1:0] i_credit;
    logic [NUM_ARRAYS-1:0] i_calc_done;
    psum_lanes_t [NUM_ARRAYS-1:0] i_psum_data;
    logic o_busy;
    logic o_done;
    logic [ADDR_WIDTH-1:0] o_rd_addr;
    slice_beat_t [NUM_ARRAYS-1:0] o_slice;
    psum_req_t o_psum_req;
    mem_wr_t o_wr;

    logic [DATA_WIDTH-1:0] mem [16384];
    logic [ADDR_WIDTH-1:0] rd_addr_q;
    logic [31:0] psum_rng;
    logic [31:0] delay_rng;
    int cycle;
    int errors;
    int credit_due[3][$];
    int recv[3];
    int given[3];
    int slice_cnt[3];
    int calc_due[3];
    bit calc_seen[3];
    int ld_layer, ld_tile, ld_slice, ld_beat;
    bit req_q;
    int req_layer_q;
    int req_k, fetch_layer, fetch_tile;
    logic [63:0] pk_word;
    int pk_n, pk_widx;
    logic [77:0] exp_wr[$];
    logic [77:0] wr_log[2][$];
    int run_idx;
    bit long_gap;
    int done_cnt;

    mlp_engine u_mlp_engine (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_start     (i_start),
        .i_rd_data   (i_rd_data),
        .i_credit    (i_credit),
        .i_calc_done (i_calc_done),
        .i_psum_data (i_psum_data),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_rd_addr   (o_rd_addr),
        .o_slice     (o_slice),
        .o_psum_req  (o_psum_req),
        .o_wr        (o_wr)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [77:0] got,
                                   input logic [77:0] exp);
        errors++;
        $display("Fail time=%0t %s got=%0h exp=%0h", $time, name, got, exp);
    endtask

    initial begin
        s_clk = 1'b0;
        forever #20 s_clk = ~s_clk;
    end

    always @(posedge s_clk) begin
        cycle <= cycle + 1;
        if (cycle > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // memory, array and reference models on the falling edge
    always @(negedge s_clk) begin
        int ch;
        int nvalid;
        int s;
        int memb;
        int exp_addr;
        logic [31:0] r;
        logic fire;
        if (!s_rst) begin
            if (o_wr.en) begin
                wr_log[run_idx].push_back({o_wr.addr, o_wr.data});
                if (exp_wr.size() == 0) begin
                    errors++;
                    $display("unexpected write at time %0t to address %0h", $time, o_wr.addr);
                end else if ({o_wr.addr, o_wr.data} != exp_wr[0]) begin
                    report_mismatch("o_wr", {o_wr.addr, o_wr.data}, exp_wr[0]);
                    void'(exp_wr.pop_front());
                end else begin
                    void'(exp_wr.pop_front());
                end
                mem[o_wr.addr] = o_wr.data;
            end
            if (o_done) begin
                done_cnt++;
                if (o_busy !== 1'b0)
                    report_mismatch("o_busy", o_busy, 0);
                if (!req_q || o_psum_req.valid) begin
                    errors++;
                    $display("o_done at time %0t was not on the cycle after the final request",
                             $time);
                end
            end
            nvalid = 0;
            for (int a = 0; a < NUM_ARRAYS; a++)
                nvalid += o_slice[a].valid;
            if (nvalid > 1) begin
                errors++;
                $display("more than one slice channel valid at time %0t", $time);
            end
            for (int a = 0; a < NUM_ARRAYS; a++) begin
                if (o_slice[a].valid) begin
                    if (a != ld_slice % 3)
                        report_mismatch("slice channel", a, ld_slice % 3);
                    exp_addr = rd_base[ld_layer] + ld_slice * 32 + ld_beat;
                    if (rd_addr_q !== ADDR_WIDTH'(exp_addr))
                        report_mismatch("o_rd_addr", rd_addr_q, exp_addr);
                    if (o_slice[a].data !== mem[exp_addr])
                        report_mismatch("o_slice.data", o_slice[a].data, mem[exp_addr]);
                    if (o_slice[a].last !== (ld_beat == 31))
                        report_mismatch("o_slice.last", o_slice[a].last, ld_beat == 31);
                    recv[a]++;
                    if (recv[a] - given[a] > CREDIT_INIT)
                        report_mismatch("outstanding beats", recv[a] - given[a], CREDIT_INIT);
                    delay_rng = xorshift32(delay_rng);
                    credit_due[a].push_back(cycle + (long_gap ? 24 + delay_rng[2:0]
                                                              : 1 + delay_rng[1:0]));
                    if (o_slice[a].last) begin
                        slice_cnt[a]++;
                        if (slice_cnt[a] == rows_tab[ld_layer] / 3) begin
                            slice_cnt[a] = 0;
                            delay_rng = xorshift32(delay_rng);
                            calc_due[a] = cycle + 2 + delay_rng[1:0];
                        end
                    end
                    ld_beat++;
                    if (ld_beat == 32) begin
                        ld_beat = 0;
                        ld_slice++;
                        if (ld_slice == rows_tab[ld_layer]) begin
                            ld_slice = 0;
                            ld_tile++;
                            if (ld_tile == cols_tab[ld_layer]) begin
                                ld_tile = 0;
                                ld_layer++;
                            end
                        end
                    end
                end
            end
            i_credit = '0;
            i_calc_done = '0;
            for (int a = 0; a < NUM_ARRAYS; a++) begin
                if (credit_due[a].size() > 0 && credit_due[a][0] <= cycle) begin
                    void'(credit_due[a].pop_front());
                    i_credit[a] = 1'b1;
                    given[a]++;
                end
                if (calc_due[a] == cycle) begin
                    i_calc_done[a] = 1'b1;
                    calc_seen[a] = 1'b1;
                end
            end
            if (o_psum_req.valid) begin
                if (!req_q) begin
                    if (!(calc_seen[0] && calc_seen[1] && calc_seen[2])) begin
                        errors++;
                        $display("fetch started at time %0t before all calc_done pulses", $time);
                    end
                    calc_seen = '{0, 0, 0};
                    req_k = 0;
                end
                if (o_busy !== 1'b1)
                    report_mismatch("o_busy", o_busy, 1);
                if (o_psum_req.grant !== 16'(1 << ((req_k / 16) % 16)))
                    report_mismatch("o_psum_req.grant", o_psum_req.grant,
                                    16'(1 << ((req_k / 16) % 16)));
                req_k++;
            end else if (req_q) begin
                if (req_k != PSUM_PER_TILE)
                    report_mismatch("requests per tile", req_k, PSUM_PER_TILE);
                fetch_tile++;
                if (fetch_tile == cols_tab[fetch_layer]) begin
                    fetch_tile = 0;
                    fetch_layer++;
                end
            end
            // array answers and the reference neuron for the previous request
            if (req_q) begin
                if (pk_n == 0)
                    pk_word = '0;
                memb = 0;
                for (int t = 0; t < TIME_STEPS; t++) begin
                    s = 0;
                    for (int a = 0; a < NUM_ARRAYS; a++) begin
                        psum_rng = xorshift32(psum_rng);
                        r = psum_rng;
                        i_psum_data[a][t] = {{10{r[9]}}, r[9:0]};
                        s += $signed(r[9:0]);
                    end
                    memb += s;
                    fire = (memb >= thresh_tab[req_layer_q]);
                    if (fire)
                        memb = 0;
                    pk_word[8 * pk_n + 2 * t] = fire;
                end
                pk_n++;
                if (pk_n == SPIKES_PER_WORD) begin
                    pk_n = 0;
                    ch = wr_base[req_layer_q] + pk_widx;
                    exp_wr.push_back({ch[13:0], pk_word});
                    pk_widx = (pk_widx == cols_tab[req_layer_q] * 32 - 1) ? 0 : pk_widx + 1;
                end
            end
            req_q = o_psum_req.valid;
            req_layer_q = fetch_layer;
            rd_addr_q = o_rd_addr;
            i_rd_data = mem[o_rd_addr];
        end
    end

    task automatic check_reset_state();
        if (o_busy !== 1'b0)
            report_mismatch("o_busy", o_busy, 0);
        if (o_done !== 1'b0)
            report_mismatch("o_done", o_done, 0);
        for (int a = 0; a < NUM_ARRAYS; a++)
            if (o_slice[a].valid !== 1'b0)
                report_mismatch("o_slice.valid", o_slice[a].valid, 0);
        if (o_psum_req.valid !== 1'b0)
            report_mismatch("o_psum_req.valid", o_psum_req.valid, 0);
        if (o_wr.en !== 1'b0)
            report_mismatch("o_wr.en", o_wr.en, 0);
    endtask

    // one full pass over the three layers
    task automatic run_layers(input int run, input bit gaps);
        run_idx = run;
        long_gap = gaps;
        psum_rng = 32'd87;
        done_cnt = 0;
        ld_layer = 0;
        ld_tile = 0;
        ld_slice = 0;
        ld_beat = 0;
        fetch_layer = 0;
        fetch_tile = 0;
        @(negedge s_clk);
        i_start = 1'b1;
        @(negedge s_clk);
        i_start = 1'b0;
        while (done_cnt == 0)
            @(negedge s_clk);
        repeat (8) @(negedge s_clk);
        if (done_cnt != 1)
            report_mismatch("o_done pulses", done_cnt, 1);
        if (o_busy !== 1'b0)
            report_mismatch("o_busy", o_busy, 0);
        if (exp_wr.size() != 0) begin
            errors++;
            $display("%0d expected writes never happened", exp_wr.size());
        end
        if (wr_log[run].size() != TOTAL_TILES * 32)
            report_mismatch("write count", wr_log[run].size(), TOTAL_TILES * 32);
    endtask

    task automatic compare_reruns();
        if (wr_log[1].size() != wr_log[0].size())
            report_mismatch("rerun write count", wr_log[1].size(), wr_log[0].size());
        else
            for (int i = 0; i < wr_log[0].size(); i++)
                if (wr_log[1][i] !== wr_log[0][i])
                    report_mismatch("rerun write", wr_log[1][i], wr_log[0][i]);
    endtask

    initial begin
        logic [31:0] x;
        cycle = 0;
        errors = 0;
        s_rst = 1'b1;
        i_start = 1'b0;
        i_rd_data = '0;
        i_credit = '0;
        i_calc_done = '0;
        i_psum_data = '0;
        rd_addr_q = '0;
        delay_rng = 32'd87;
        req_q = 1'b0;
        pk_n = 0;
        pk_widx = 0;
        run_idx = 0;
        for (int a = 0; a < NUM_ARRAYS; a++) begin
            recv[a] = 0;
            given[a] = 0;
            slice_cnt[a] = 0;
            calc_due[a] = -1;
            calc_seen[a] = 1'b0;
        end
        for (int i = 0; i < 16384; i++)
            mem[i] = {32'(i) * 32'h9e3779b1, 18'h0, 14'(i)};
        x = 32'd87;
        for (int i = 0; i < 1024; i++) begin
            x = xorshift32(x);
            mem[i][63:32] = x;
            x = xorshift32(x);
            mem[i][31:0] = x;
        end
        repeat (5) @(posedge s_clk);
        @(negedge s_clk);
        s_rst = 1'b0;
        check_reset_state();
        run_layers(0, 1'b0);
        run_layers(1, 1'b1);
        compare_reruns();
        $display("errors=%0d cycles=%0d", errors, cycle);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: files.f
hw/mlp_pkg.sv
hw/mlp_sequencer.sv
hw/slice_streamer.sv
hw/psum_combiner.sv
hw/lif_neuron.sv
hw/spike_packer.sv
hw/mlp_engine.sv
test/tb_mlp_engine.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -Wno-fatal
TOP       ?= tb_mlp_engine
FILELIST  ?= files.f
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
